/* video_pkg.sv */
// video pixel types
// ARGB4444 input pixels, RGB444 output pixels and the widened
// channel, product and sum vectors of the blend datapath

package video_pkg;

    // ARGB4444 pixel, alpha in [15:12], then red, green, blue
    typedef logic [15:0] argb_t;

    // RGB444 output pixel
    typedef logic [11:0] rgb_t;

    // single colour channel or alpha nibble
    typedef logic [3:0]  nibble_t;

    // channel or weight widened to 8 bits
    typedef logic [7:0]  chan8_t;

    // 8x8 channel times weight
    typedef logic [15:0] product_t;

    // two 7-bit product tops added, bit 7 is overflow
    typedef logic [7:0]  sum_t;

    // flag bits carried in the alpha nibble of pixel A
    localparam int A_OPAQUE_BIT = 15;      // A drawn at full weight
    localparam int A_HIDE_B_BIT = 14;      // B contributes nothing

    // nibble repeat, 0xA -> 0xAA, keeps 0 and F exact
    function automatic chan8_t widen(input nibble_t n);
        return {n, n};
    endfunction

endpackage

/* blend_pkg.sv */
// blend pipeline constants
// latency of the three-stage blender, the two weight extremes and
// the bit positions used when the products are summed and clipped

package blend_pkg;

    // widen, multiply, combine
    localparam int BLEND_LATENCY = 3;

    // weight applied to an opaque A pixel
    localparam video_pkg::chan8_t WEIGHT_FULL = 8'hFF;
    // weight applied to a hidden B pixel
    localparam video_pkg::chan8_t WEIGHT_NONE = 8'h00;

    // product bits carried into the sum
    localparam int PROD_KEEP_MSB = 15;
    localparam int PROD_KEEP_LSB = 9;

    // sum overflow bit, result nibble sits just below it
    localparam int SAT_BIT = 7;

endpackage

/* alpha_select.sv */
// blend stage 1
// widens the six colour nibbles of pixels A and B to 8 bits and
// picks the two blend weights from B's alpha, steered by the
// opaque and hide-B flags of pixel A

`timescale 1ns/1ps

module alpha_select (
    input  logic               clk,
    input  logic               rst_n_i,
    input  video_pkg::argb_t   color_a_i,
    input  video_pkg::argb_t   color_b_i,
    output video_pkg::chan8_t  a_r_o,
    output video_pkg::chan8_t  a_g_o,
    output video_pkg::chan8_t  a_b_o,
    output video_pkg::chan8_t  b_r_o,
    output video_pkg::chan8_t  b_g_o,
    output video_pkg::chan8_t  b_b_o,
    output video_pkg::chan8_t  weight_a_o,
    output video_pkg::chan8_t  weight_b_o
);

    import video_pkg::*;
    import blend_pkg::*;

    nibble_t alpha_b;                              // B alpha nibble

    assign alpha_b = color_b_i[15:12];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            a_r_o      <= '0;
            a_g_o      <= '0;
            a_b_o      <= '0;
            b_r_o      <= '0;
            b_g_o      <= '0;
            b_b_o      <= '0;
            weight_a_o <= '0;
            weight_b_o <= '0;
        end else begin
            a_r_o      <= widen(color_a_i[11:8]);  // A red
            a_g_o      <= widen(color_a_i[7:4]);   // A green
            a_b_o      <= widen(color_a_i[3:0]);   // A blue
            b_r_o      <= widen(color_b_i[11:8]);  // B red
            b_g_o      <= widen(color_b_i[7:4]);   // B green
            b_b_o      <= widen(color_b_i[3:0]);   // B blue

            // A weight is full or 1 - alpha B
            if (color_a_i[A_OPAQUE_BIT]) begin
                weight_a_o <= WEIGHT_FULL;
            end else begin
                weight_a_o <= widen(~alpha_b);
            end

            // B weight is alpha B unless A hides it
            if (color_a_i[A_HIDE_B_BIT]) begin
                weight_b_o <= WEIGHT_NONE;
            end else begin
                weight_b_o <= widen(alpha_b);
            end
        end
    end

endmodule

/* channel_mac.sv */
// blend stage 2, one colour channel
// registered pair of unsigned 8x8 multiplies, A channel by A weight
// and B channel by B weight, as a dual-multiplier DSP would do

`timescale 1ns/1ps

module channel_mac (
    input  logic                clk,
    input  logic                rst_n_i,
    input  video_pkg::chan8_t   chan_a_i,
    input  video_pkg::chan8_t   chan_b_i,
    input  video_pkg::chan8_t   weight_a_i,
    input  video_pkg::chan8_t   weight_b_i,
    output video_pkg::product_t prod_a_o,
    output video_pkg::product_t prod_b_o
);

    import video_pkg::*;

    product_t mul_a;                               // A side product
    product_t mul_b;                               // B side product

    always_comb begin
        mul_a = product_t'(chan_a_i) * product_t'(weight_a_i);
        mul_b = product_t'(chan_b_i) * product_t'(weight_b_i);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prod_a_o <= '0;
            prod_b_o <= '0;
        end else begin
            prod_a_o <= mul_a;                     // max FF*FF fits 16 bits
            prod_b_o <= mul_b;
        end
    end

endmodule

/* blend_combine.sv */
// blend stage 3
// adds the upper 7 bits of each A/B product pair, clips each
// channel to F on overflow and blanks the pixel outside display

`timescale 1ns/1ps

module blend_combine (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                de_i,
    input  video_pkg::product_t prod_ar_i,
    input  video_pkg::product_t prod_br_i,
    input  video_pkg::product_t prod_ag_i,
    input  video_pkg::product_t prod_bg_i,
    input  video_pkg::product_t prod_ab_i,
    input  video_pkg::product_t prod_bb_i,
    output video_pkg::rgb_t     blend_rgb_o
);

    import video_pkg::*;
    import blend_pkg::*;

    sum_t sum_r;                                   // red, bit 7 overflow
    sum_t sum_g;
    sum_t sum_b;

    // kept product tops, zero extended into the sum width
    function automatic sum_t add_tops(input product_t pa, input product_t pb);
        return sum_t'(pa[PROD_KEEP_MSB:PROD_KEEP_LSB])
             + sum_t'(pb[PROD_KEEP_MSB:PROD_KEEP_LSB]);
    endfunction

    // clip on overflow, else the four bits under it
    function automatic nibble_t clip(input sum_t s);
        return s[SAT_BIT] ? 4'hF : s[SAT_BIT-1 -: 4];
    endfunction

    always_comb begin
        sum_r = add_tops(prod_ar_i, prod_br_i);
        sum_g = add_tops(prod_ag_i, prod_bg_i);
        sum_b = add_tops(prod_ab_i, prod_bb_i);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            blend_rgb_o <= '0;
        end else if (de_i) begin
            blend_rgb_o <= {clip(sum_r), clip(sum_g), clip(sum_b)};
        end else begin
            blend_rgb_o <= '0;                     // black in blanking
        end
    end

endmodule

/* sync_delay.sv */
// timing signal delay
// shifts hsync, vsync and display enable DEPTH cycles so they leave
// with the matching pixel, and taps enable one stage early for
// the blanking decision in the last colour stage

`timescale 1ns/1ps

module sync_delay #(
    parameter int DEPTH = 3                        // at least 2
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic hsync_i,
    input  logic vsync_i,
    input  logic de_i,
    output logic de_mid_o,
    output logic hsync_o,
    output logic vsync_o,
    output logic de_o
);

    logic [2:0] sync_q [DEPTH];                    // {de, vsync, hsync} per stage

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= {de_i, vsync_i, hsync_i};
            for (int i = 1; i < DEPTH; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign de_mid_o = sync_q[DEPTH-2][2];          // DEPTH-1 cycles late
    assign de_o     = sync_q[DEPTH-1][2];
    assign vsync_o  = sync_q[DEPTH-1][1];
    assign hsync_o  = sync_q[DEPTH-1][0];

endmodule

/* blend_top.sv */
// two-layer ARGB4444 pixel blender
// three-stage pipeline, widen and weigh, multiply, then add, clip
// and blank, with the video timing delayed to match

`timescale 1ns/1ps

module blend_top #(
    parameter int SYNC_DEPTH = blend_pkg::BLEND_LATENCY
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             vsync_i,
    input  logic             hsync_i,
    input  logic             dv_de_i,
    input  video_pkg::argb_t color_a_i,
    input  video_pkg::argb_t color_b_i,
    output video_pkg::rgb_t  blend_rgb_o,
    output logic             hsync_o,
    output logic             vsync_o,
    output logic             dv_de_o
);

    import video_pkg::*;

    chan8_t   a_r, a_g, a_b;                       // widened A channels
    chan8_t   b_r, b_g, b_b;                       // widened B channels
    chan8_t   weight_a;
    chan8_t   weight_b;
    product_t prod_ar, prod_br;                    // red products
    product_t prod_ag, prod_bg;                    // green products
    product_t prod_ab, prod_bb;                    // blue products
    logic     de_mid;                              // enable aligned with products

    alpha_select u_alpha_select (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .color_a_i  (color_a_i),
        .color_b_i  (color_b_i),
        .a_r_o      (a_r),
        .a_g_o      (a_g),
        .a_b_o      (a_b),
        .b_r_o      (b_r),
        .b_g_o      (b_g),
        .b_b_o      (b_b),
        .weight_a_o (weight_a),
        .weight_b_o (weight_b)
    );

    channel_mac u_mac_r (
        .clk(clk), .rst_n_i(rst_n_i),
        .chan_a_i(a_r), .chan_b_i(b_r),
        .weight_a_i(weight_a), .weight_b_i(weight_b),
        .prod_a_o(prod_ar), .prod_b_o(prod_br)
    );

    channel_mac u_mac_g (
        .clk(clk), .rst_n_i(rst_n_i),
        .chan_a_i(a_g), .chan_b_i(b_g),
        .weight_a_i(weight_a), .weight_b_i(weight_b),
        .prod_a_o(prod_ag), .prod_b_o(prod_bg)
    );

    channel_mac u_mac_b (
        .clk(clk), .rst_n_i(rst_n_i),
        .chan_a_i(a_b), .chan_b_i(b_b),
        .weight_a_i(weight_a), .weight_b_i(weight_b),
        .prod_a_o(prod_ab), .prod_b_o(prod_bb)
    );

    blend_combine u_blend_combine (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .de_i        (de_mid),
        .prod_ar_i   (prod_ar),
        .prod_br_i   (prod_br),
        .prod_ag_i   (prod_ag),
        .prod_bg_i   (prod_bg),
        .prod_ab_i   (prod_ab),
        .prod_bb_i   (prod_bb),
        .blend_rgb_o (blend_rgb_o)
    );

    sync_delay #(
        .DEPTH (SYNC_DEPTH)
    ) u_sync_delay (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .hsync_i  (hsync_i),
        .vsync_i  (vsync_i),
        .de_i     (dv_de_i),
        .de_mid_o (de_mid),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o),
        .de_o     (dv_de_o)
    );

endmodule

/* blend_chk.sv */
// blend pipeline checker
// bound into the blender top level, keeps a three-deep history of
// the input pixels and timing, rebuilds the expected output pixel
// from the blend rule and asserts it against the DUT every cycle

`timescale 1ns/1ps

module blend_chk (
    input logic             clk,
    input logic             rst_n_i,
    input logic             vsync_i,
    input logic             hsync_i,
    input logic             dv_de_i,
    input video_pkg::argb_t color_a_i,
    input video_pkg::argb_t color_b_i,
    input video_pkg::rgb_t  blend_rgb_o,
    input logic             hsync_o,
    input logic             vsync_o,
    input logic             dv_de_o
);

    import video_pkg::*;

    logic       fail_flag = 1'b0;                  // watched by the testbench
    argb_t      hist_a [3];                        // [0] newest pixel A
    argb_t      hist_b [3];
    logic [2:0] hist_sync [3];                     // {de, vsync, hsync}
    rgb_t       exp_rgb;                           // pixel due at the output now

    // blend rule in plain integer arithmetic
    function automatic rgb_t blend_ref(input argb_t a, input argb_t b, input logic de);
        int   wa;
        int   wb;
        int   ca;
        int   cb;
        int   s;
        rgb_t r;
        r = '0;
        if (de) begin
            wa = a[15] ? 255 : (15 - int'(b[15:12])) * 17;  // opaque A or 1 - alpha B
            wb = a[14] ? 0 : int'(b[15:12]) * 17;           // hide-B or alpha B
            for (int i = 0; i < 3; i++) begin
                ca = int'(a[4*i +: 4]) * 17;       // nibble widened to 8 bits
                cb = int'(b[4*i +: 4]) * 17;
                s  = ((ca * wa) >> 9) + ((cb * wb) >> 9);
                r[4*i +: 4] = (s >= 128) ? 4'hF : 4'((s >> 3) & 15);
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 3; i++) begin
                hist_a[i]    <= '0;
                hist_b[i]    <= '0;
                hist_sync[i] <= '0;
            end
        end else begin
            hist_a[0]    <= color_a_i;
            hist_b[0]    <= color_b_i;
            hist_sync[0] <= {dv_de_i, vsync_i, hsync_i};
            for (int i = 1; i < 3; i++) begin
                hist_a[i]    <= hist_a[i-1];
                hist_b[i]    <= hist_b[i-1];
                hist_sync[i] <= hist_sync[i-1];
            end
        end
    end

    always_comb begin
        exp_rgb = blend_ref(hist_a[2], hist_b[2], hist_sync[2][2]);
    end

    a_rgb: assert property (@(posedge clk) blend_rgb_o == exp_rgb)
        else begin
            fail_flag = 1'b1;
            $error("MISMATCH t=%0t blend_rgb_o expected=%h actual=%h",
                   $time, $sampled(exp_rgb), $sampled(blend_rgb_o));
        end

    a_hsync: assert property (@(posedge clk) hsync_o == hist_sync[2][0])
        else begin
            fail_flag = 1'b1;
            $error("MISMATCH t=%0t hsync_o expected=%b actual=%b",
                   $time, $sampled(hist_sync[2][0]), $sampled(hsync_o));
        end

    a_vsync: assert property (@(posedge clk) vsync_o == hist_sync[2][1])
        else begin
            fail_flag = 1'b1;
            $error("MISMATCH t=%0t vsync_o expected=%b actual=%b",
                   $time, $sampled(hist_sync[2][1]), $sampled(vsync_o));
        end

    a_de: assert property (@(posedge clk) dv_de_o == hist_sync[2][2])
        else begin
            fail_flag = 1'b1;
            $error("MISMATCH t=%0t dv_de_o expected=%b actual=%b",
                   $time, $sampled(hist_sync[2][2]), $sampled(dv_de_o));
        end

    // outside display the pixel must be black
    a_black: assert property (@(posedge clk) !hist_sync[2][2] |-> blend_rgb_o == '0)
        else begin
            fail_flag = 1'b1;
            $error("MISMATCH t=%0t blend_rgb_o expected=000 actual=%h in blanking",
                   $time, $sampled(blend_rgb_o));
        end

    a_reset: assert property (@(posedge clk)
            !rst_n_i |-> (blend_rgb_o == '0 && !hsync_o && !vsync_o && !dv_de_o))
        else begin
            fail_flag = 1'b1;
            $error("outputs were not idle while reset was held");
        end

endmodule

bind blend_top blend_chk u_chk (.*);

/* blend_tb.sv */
// blender testbench
// drives reset, random sync patterns, an opaque-A sweep, hide-B
// pixels and random blends into the DUT; checking is done by the
// bound checker, whose failure flag is watched here

`timescale 1ns/1ps

module blend_tb;

    import video_pkg::*;
    import blend_pkg::*;

    // reset, idle, sync, opaque sweep, hide-B, random, flush
    localparam int STIM_CYCLES    = 5 + 4 + 100 + 256 + 64 + 150 + 5;
    // three times the stimulus, rounded up to a multiple of 500
    localparam int TIMEOUT_CYCLES = (STIM_CYCLES * 3 + 499) / 500 * 500;

    logic   clk;
    logic   rst_n_i;
    logic   vsync_i;
    logic   hsync_i;
    logic   dv_de_i;
    argb_t  color_a_i;
    argb_t  color_b_i;
    rgb_t   blend_rgb_o;
    logic   hsync_o;
    logic   vsync_o;
    logic   dv_de_o;

    integer seed = 32'hf814;                       // $random state
    int     cycle_count = 0;

    blend_top DUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .vsync_i     (vsync_i),
        .hsync_i     (hsync_i),
        .dv_de_i     (dv_de_i),
        .color_a_i   (color_a_i),
        .color_b_i   (color_b_i),
        .blend_rgb_o (blend_rgb_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o),
        .dv_de_o     (dv_de_o)
    );

    always #4 clk = ~clk;                          // 8 ns period

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped on failure");
    endtask

    function automatic argb_t rand_pixel();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    // one pixel per clock, syncs random
    task automatic drive_cycle(input argb_t a, input argb_t b, input logic de);
        logic [31:0] r;
        r = $random(seed);
        @(posedge clk);
        color_a_i <= a;
        color_b_i <= b;
        dv_de_i   <= de;
        hsync_i   <= r[0];
        vsync_i   <= r[1];
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_failure("timeout, the stimulus did not finish within the cycle limit");
        end
    end

    always @(posedge clk) begin
        if (DUT.u_chk.fail_flag) begin
            stop_on_failure("a checker assertion failed, see the error above");
        end
    end

    initial begin
        logic [3:0] an;
        logic [3:0] bn;
        argb_t      a;
        argb_t      b;
        clk       = 1'b0;
        rst_n_i   = 1'b0;
        vsync_i   = 1'b0;
        hsync_i   = 1'b0;
        dv_de_i   = 1'b0;
        color_a_i = '0;
        color_b_i = '0;

        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (4) @(posedge clk);                 // outputs stay idle after release

        // random timing patterns
        for (int i = 0; i < 100; i++) begin
            drive_cycle(rand_pixel(), rand_pixel(), rand_bit());
        end

        // opaque A over every A and B level, top levels saturate
        for (int ai = 0; ai < 16; ai++) begin
            for (int bi = 0; bi < 16; bi++) begin
                an = 4'(ai);
                bn = 4'(bi);
                a  = {2'b10, an[1:0], an, an, an};
                b  = {bn, bn, ~bn, bn};
                drive_cycle(a, b, 1'b1);
            end
        end

        // hide-B, half of them also opaque
        for (int i = 0; i < 64; i++) begin
            a     = rand_pixel();
            a[14] = 1'b1;
            a[15] = i[0];
            drive_cycle(a, rand_pixel(), 1'b1);
        end

        // random blend with random blanking
        for (int i = 0; i < 150; i++) begin
            drive_cycle(rand_pixel(), rand_pixel(), rand_bit());
        end

        repeat (BLEND_LATENCY + 2) begin
            drive_cycle(16'h0000, 16'h0000, 1'b0);
        end
        @(posedge clk);

        if (DUT.u_chk.fail_flag) begin
            stop_on_failure("the checker flagged a failure");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* blend_top.f */
video_pkg.sv
blend_pkg.sv
alpha_select.sv
channel_mac.sv
blend_combine.sv
sync_delay.sv
blend_top.sv
blend_chk.sv
blend_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert
TOP       = blend_tb
FILELIST  = blend_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
# let assertion errors reach the testbench instead of stopping at the first
SIM_ARGS  = +verilator+error+limit+1000

.PHONY: test clean help

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   list the targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
